//--- booth_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module booth_multiplier (
    input  logic               clk,
    input  logic               RST_n,
    input  rv_core_pkg::word_t a,
    input  rv_core_pkg::word_t b,
    output rv_core_pkg::word_t product
);

    logic [rv_core_pkg::xlen:0] b_ext;
    rv_core_pkg::word_t         pp;
    rv_core_pkg::word_t         sum_lo;
    rv_core_pkg::word_t         sum_hi;
    rv_core_pkg::word_t         sum_lo_q;
    rv_core_pkg::word_t         sum_hi_q;

    // One partial product from a recoded triplet, modulo 2^32
    function automatic rv_core_pkg::word_t booth_pp(input logic [2:0] sel,
                                                    input rv_core_pkg::word_t m);
        case (sel)
            3'b001, 3'b010: return m;
            3'b011:         return m << 1;
            3'b100:         return -(m << 1);
            3'b101, 3'b110: return -m;
            default:        return '0;  // 000 and 111
        endcase
    endfunction

    assign b_ext = {b, 1'b0};  // Implicit b[-1]

    always_comb begin
        sum_lo = '0;
        sum_hi = '0;
        pp     = '0;
        for (int i = 0; i < rv_core_pkg::booth_digits; i++) begin
            pp = booth_pp(b_ext[2*i +: 3], a) << (2*i);
            if (i < rv_core_pkg::booth_digits/2) begin
                sum_lo = sum_lo + pp;
            end else begin
                sum_hi = sum_hi + pp;
            end
        end
    end

    // Execute to result boundary
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            sum_lo_q <= '0;
            sum_hi_q <= '0;
        end else begin
            sum_lo_q <= sum_lo;
            sum_hi_q <= sum_hi;
        end
    end

    assign product = sum_lo_q + sum_hi_q;  // Final add in result stage

endmodule

`default_nettype wire

//--- filelist.f
rv_core_pkg.sv
rv_regfile.sv
rv_decode.sv
booth_multiplier.sv
rv_execute.sv
rv_result.sv
rv_wb_core.sv
rv_core_asserts.sv
rv_core_checker.sv
tb_rv_core.sv

//--- rv_core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_asserts (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   ack,
    input  logic                   wen,
    input  rv_core_pkg::reg_addr_t waddr
);

    int fail_count = 0;  // Read by the testbench summary

    // Host holds the request until it has seen ack
    ack_needs_request: assert property (@(posedge clk) disable iff (!RST_n)
        ack |-> (cyc && stb))
        else begin
            fail_count++;
            $error("ack raised without cyc and stb");
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!RST_n)
        ack |=> !ack)
        else begin
            fail_count++;
            $error("ack held high for two cycles");
        end

    // x0 is never a write target
    no_x0_write: assert property (@(posedge clk) disable iff (!RST_n)
        wen |-> (waddr != '0))
        else begin
            fail_count++;
            $error("register file write enabled for x0");
        end

endmodule

bind rv_wb_core rv_core_asserts u_rv_core_asserts (
    .clk   (clk),
    .RST_n (RST_n),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .wen   (wen),
    .waddr (waddr)
);

`default_nettype wire

//--- rv_core_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_checker (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic                   ack,
    input  rv_core_pkg::word_t     dat_r
);

    int                     test_count  = 0;
    int                     check_count = 0;
    int                     error_count = 0;
    int                     test_checks = 0;
    int                     test_errors = 0;
    string                  test_name   = "(none)";
    rv_core_pkg::reg_addr_t exp_reg_q[$];
    rv_core_pkg::word_t     exp_val_q[$];
    rv_core_pkg::reg_addr_t exp_reg;
    rv_core_pkg::word_t     exp_val;

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %-16s %0d reads, %0d mismatches, %s", test_name, test_checks,
                 test_errors, (test_errors == 0) ? "ok" : "failed");
    endtask

    // Queued in request order, popped at each read ack
    task automatic expect_read(input rv_core_pkg::reg_addr_t r, input rv_core_pkg::word_t v);
        exp_reg_q.push_back(r);
        exp_val_q.push_back(v);
    endtask

    function automatic int pending();
        return exp_val_q.size();
    endfunction

    // ack and dat_r are registered, settled by the falling edge
    always @(negedge clk) begin
        if (RST_n && ack && cyc && stb && !we) begin
            if (exp_val_q.size() == 0) begin
                $display("Read acknowledged at %0t with no expected value waiting", $time);
                error_count++;
                test_errors++;
            end else begin
                exp_reg = exp_reg_q.pop_front();
                exp_val = exp_val_q.pop_front();
                check_count++;
                test_checks++;
                if (dat_r !== exp_val) begin
                    $display("[FAIL] %0t: test %s, x%0d read %h, expected %h",
                             $time, test_name, exp_reg, dat_r, exp_val);
                    error_count++;
                    test_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;      // Data and instruction words
    typedef logic [4:0]      reg_addr_t;  // Register index
    typedef logic [4:0]      shamt_t;     // Shift amount
    typedef logic [6:0]      opcode_t;    // Major opcode field

    // Major opcodes kept by the core
    localparam opcode_t op_reg = 7'b0110011;
    localparam opcode_t op_imm = 7'b0010011;

    // funct3 encodings
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;  // Rejected by decode
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct7 encodings
    localparam logic [6:0] f7_alt    = 7'b0100000;  // SUB and SRA
    localparam logic [6:0] f7_muldiv = 7'b0000001;  // M extension

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt
    } alu_op_e;

    // Radix-4 digits covering a 32-bit multiplier
    localparam int booth_digits = 16;

endpackage

`default_nettype wire

//--- rv_core_vectors.txt
# Columns: T <test name> | I <instruction hex> | R <register decimal> <expected hex>
# T starts a test, I issues an instruction, R reads a register and checks its value
T imm_arith
R 1 00000000
R 31 00000000
I 00500093
I FFD00113
I 0F017193
I 7000E213
I FFF14293
I 00112313
I FFF0A393
R 1 00000005
R 2 FFFFFFFD
R 3 000000F0
R 4 00000705
R 5 00000002
R 6 00000001
R 7 00000000
T reg_alu
I 00208533
I 402085B3
I 00417633
I 0030E6B3
I 00414733
I 001127B3
I 00409833
I 001158B3
I 40115933
I 40115993
I 01F09A93
R 10 00000002
R 11 00000008
R 12 00000705
R 13 000000F5
R 14 FFFFF8F8
R 15 00000001
R 16 000000A0
R 17 07FFFFFF
R 18 FFFFFFFF
R 19 FFFFFFFE
R 21 80000000
T forwarding
I 00300B13
I 002B1B13
I 016B0BB3
I 401B8BB3
I 016BCB33
R 22 0000001F
R 23 00000013
T multiply
I FF900C13
I 12300C93
I 039C0D33
I 018D0DB3
I 038C0E33
R 26 FFFFF80B
R 27 FFFFF804
R 28 00000031
T x0_and_illegal
I 00708013
I 001130B3
I 00103113
I 123451B7
R 0 00000000
R 1 00000005
R 2 FFFFFFFD
R 3 000000F0

//--- rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   issue,
    input  rv_core_pkg::word_t     instr,
    output logic                   hold,
    output logic                   dec_valid,
    output logic                   ex_valid,
    output rv_core_pkg::alu_op_e   ex_alu_op,
    output logic                   ex_is_mul,
    output rv_core_pkg::reg_addr_t ex_rd,
    output rv_core_pkg::word_t     ex_op_a,
    output rv_core_pkg::word_t     ex_op_b,
    input  rv_core_pkg::word_t     exe_alu,
    input  logic                   exe_is_mul,
    input  logic                   rs_valid,
    input  logic                   rs_is_mul,
    input  rv_core_pkg::reg_addr_t rs_rd,
    input  logic                   rs_wen,
    input  rv_core_pkg::word_t     rs_alu,
    input  rv_core_pkg::word_t     mul_product,
    input  rv_core_pkg::word_t     rd_a,
    input  rv_core_pkg::word_t     rd_b,
    output rv_core_pkg::reg_addr_t ra,
    output rv_core_pkg::reg_addr_t rb
);

    rv_core_pkg::word_t     dec_instr;
    rv_core_pkg::opcode_t   opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    rv_core_pkg::alu_op_e   alu_op;
    logic                   is_mul;
    logic                   legal;
    logic                   use_b;   // R-type reads rs2
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     imm;
    rv_core_pkg::word_t     rs_val;
    rv_core_pkg::word_t     fwd_a;
    rv_core_pkg::word_t     fwd_b;

    // Decode slot, kept while the interlock holds
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            dec_valid <= 1'b0;
        end else if (issue) begin
            dec_valid <= 1'b1;
        end else if (!hold) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            dec_instr <= instr;
        end
    end

    assign opcode = dec_instr[6:0];
    assign funct3 = dec_instr[14:12];
    assign funct7 = dec_instr[31:25];
    assign ra     = dec_instr[19:15];
    assign rb     = dec_instr[24:20];
    assign imm    = {{20{dec_instr[31]}}, dec_instr[31:20]};

    always_comb begin
        alu_op = rv_core_pkg::alu_add;
        is_mul = 1'b0;
        legal  = 1'b0;
        use_b  = (opcode == rv_core_pkg::op_reg);

        case (funct3)
            rv_core_pkg::f3_add: alu_op = (use_b && dec_instr[30]) ? rv_core_pkg::alu_sub
                                                                   : rv_core_pkg::alu_add;
            rv_core_pkg::f3_sll: alu_op = rv_core_pkg::alu_sll;
            rv_core_pkg::f3_slt: alu_op = rv_core_pkg::alu_slt;
            rv_core_pkg::f3_xor: alu_op = rv_core_pkg::alu_xor;
            rv_core_pkg::f3_sr:  alu_op = dec_instr[30] ? rv_core_pkg::alu_sra
                                                        : rv_core_pkg::alu_srl;
            rv_core_pkg::f3_or:  alu_op = rv_core_pkg::alu_or;
            rv_core_pkg::f3_and: alu_op = rv_core_pkg::alu_and;
            default:             alu_op = rv_core_pkg::alu_add;
        endcase

        if (opcode == rv_core_pkg::op_imm) begin
            legal = (funct3 != rv_core_pkg::f3_sltu);
        end else if (opcode == rv_core_pkg::op_reg) begin
            if (funct7 == rv_core_pkg::f7_muldiv) begin
                is_mul = (funct3 == rv_core_pkg::f3_add);  // MUL only
                legal  = is_mul;
            end else begin
                legal = (funct3 != rv_core_pkg::f3_sltu) &&
                        ((funct7 == '0) ||
                         ((funct7 == rv_core_pkg::f7_alt) &&
                          ((funct3 == rv_core_pkg::f3_add) || (funct3 == rv_core_pkg::f3_sr))));
            end
        end
    end

    // Rejected encodings retire with no destination
    assign rd = legal ? dec_instr[11:7] : '0;

    function automatic logic ex_match(input rv_core_pkg::reg_addr_t src);
        return ex_valid && (ex_rd != '0) && (ex_rd == src);
    endfunction

    function automatic logic rs_match(input rv_core_pkg::reg_addr_t src);
        return rs_valid && rs_wen && (rs_rd == src);
    endfunction

    assign rs_val = rs_is_mul ? mul_product : rs_alu;

    always_comb begin
        fwd_a = ex_match(ra) ? exe_alu : (rs_match(ra) ? rs_val : rd_a);
        fwd_b = ex_match(rb) ? exe_alu : (rs_match(rb) ? rs_val : rd_b);
        // Product not ready until the result stage
        hold  = dec_valid && exe_is_mul && (ex_match(ra) || (use_b && ex_match(rb)));
    end

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            ex_valid  <= 1'b0;
            ex_is_mul <= 1'b0;
            ex_rd     <= '0;
        end else begin
            ex_valid  <= dec_valid && !hold;  // Bubble on hold
            ex_is_mul <= is_mul;
            ex_rd     <= rd;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op <= alu_op;
        ex_op_a   <= fwd_a;
        ex_op_b   <= use_b ? fwd_b : imm;
    end

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   ex_valid,
    input  rv_core_pkg::alu_op_e   ex_alu_op,
    input  logic                   ex_is_mul,
    input  rv_core_pkg::reg_addr_t ex_rd,
    input  rv_core_pkg::word_t     ex_op_a,
    input  rv_core_pkg::word_t     ex_op_b,
    output rv_core_pkg::word_t     exe_alu,
    output logic                   exe_is_mul,
    output logic                   rs_valid,
    output logic                   rs_is_mul,
    output rv_core_pkg::reg_addr_t rs_rd,
    output logic                   rs_wen,
    output rv_core_pkg::word_t     rs_alu,
    output rv_core_pkg::word_t     mul_product
);

    rv_core_pkg::shamt_t sh;

    assign sh = ex_op_b[4:0];  // Low 5 bits only

    always_comb begin
        case (ex_alu_op)
            rv_core_pkg::alu_add: exe_alu = ex_op_a + ex_op_b;
            rv_core_pkg::alu_sub: exe_alu = ex_op_a - ex_op_b;
            rv_core_pkg::alu_and: exe_alu = ex_op_a & ex_op_b;
            rv_core_pkg::alu_or:  exe_alu = ex_op_a | ex_op_b;
            rv_core_pkg::alu_xor: exe_alu = ex_op_a ^ ex_op_b;
            rv_core_pkg::alu_sll: exe_alu = ex_op_a << sh;
            rv_core_pkg::alu_srl: exe_alu = ex_op_a >> sh;
            rv_core_pkg::alu_sra: exe_alu = $signed(ex_op_a) >>> sh;
            rv_core_pkg::alu_slt: exe_alu = {{(rv_core_pkg::xlen-1){1'b0}},
                                             $signed(ex_op_a) < $signed(ex_op_b)};
            default:              exe_alu = '0;
        endcase
    end

    assign exe_is_mul = ex_valid && ex_is_mul;

    // Result-stage register
    always_ff @(posedge clk) begin
        if (!RST_n) begin
            rs_valid  <= 1'b0;
            rs_is_mul <= 1'b0;
            rs_rd     <= '0;
            rs_wen    <= 1'b0;
        end else begin
            rs_valid  <= ex_valid;
            rs_is_mul <= ex_is_mul;
            rs_rd     <= ex_rd;
            rs_wen    <= (ex_rd != '0);  // x0 and rejected encodings
        end
    end

    always_ff @(posedge clk) begin
        rs_alu <= exe_alu;
    end

    // Operands go in every cycle, product shows up one cycle later
    booth_multiplier u_booth_multiplier (
        .clk     (clk),
        .RST_n   (RST_n),
        .a       (ex_op_a),
        .b       (ex_op_b),
        .product (mul_product)
    );

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic                  clk,
    input  logic                  RST_n,
    input  rv_core_pkg::reg_addr_t raddr_a,
    input  rv_core_pkg::reg_addr_t raddr_b,
    output rv_core_pkg::word_t     rdata_a,
    output rv_core_pkg::word_t     rdata_b,
    input  logic                  wen,
    input  rv_core_pkg::reg_addr_t waddr,
    input  rv_core_pkg::word_t     wdata
);

    rv_core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- rv_result.sv
`timescale 1ns/100ps
`default_nettype none

module rv_result (
    input  logic                   rs_valid,
    input  logic                   rs_is_mul,
    input  rv_core_pkg::reg_addr_t rs_rd,
    input  logic                   rs_wen,
    input  rv_core_pkg::word_t     rs_alu,
    input  rv_core_pkg::word_t     mul_product,
    output logic                   wen,
    output rv_core_pkg::reg_addr_t waddr,
    output rv_core_pkg::word_t     wdata
);

    // rs_wen is already low for x0
    assign wen   = rs_valid && rs_wen;
    assign waddr = rs_rd;
    assign wdata = rs_is_mul ? mul_product : rs_alu;

endmodule

`default_nettype wire

//--- rv_wb_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_wb_core (
    input  logic                   clk,
    input  logic                   RST_n,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  rv_core_pkg::reg_addr_t adr,
    input  rv_core_pkg::word_t     dat_w,
    output rv_core_pkg::word_t     dat_r,
    output logic                   ack
);

    logic                   issue;
    logic                   hold;
    logic                   dec_valid;
    logic                   rd_req;
    logic                   pipe_empty;
    logic                   ex_valid;
    rv_core_pkg::alu_op_e   ex_alu_op;
    logic                   ex_is_mul;
    rv_core_pkg::reg_addr_t ex_rd;
    rv_core_pkg::word_t     ex_op_a;
    rv_core_pkg::word_t     ex_op_b;
    rv_core_pkg::word_t     exe_alu;
    logic                   exe_is_mul;
    logic                   rs_valid;
    logic                   rs_is_mul;
    rv_core_pkg::reg_addr_t rs_rd;
    logic                   rs_wen;
    rv_core_pkg::word_t     rs_alu;
    rv_core_pkg::word_t     mul_product;
    rv_core_pkg::reg_addr_t ra;
    rv_core_pkg::reg_addr_t rb;
    rv_core_pkg::reg_addr_t rf_raddr_a;
    rv_core_pkg::word_t     rd_a;
    rv_core_pkg::word_t     rd_b;
    logic                   wen;
    rv_core_pkg::reg_addr_t waddr;
    rv_core_pkg::word_t     wdata;

    assign pipe_empty = !dec_valid && !ex_valid && !rs_valid;

    // !ack keeps each request to a single acknowledge
    assign issue  = cyc && stb && we && !ack && !hold;
    assign rd_req = cyc && stb && !we && !ack && pipe_empty;

    // Host read borrows port a only once decode is idle
    assign rf_raddr_a = rd_req ? adr : ra;

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            ack <= 1'b0;
        end else begin
            ack <= issue || rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            dat_r <= rd_a;
        end
    end

    rv_decode u_rv_decode (
        .clk         (clk),
        .RST_n       (RST_n),
        .issue       (issue),
        .instr       (dat_w),
        .hold        (hold),
        .dec_valid   (dec_valid),
        .ex_valid    (ex_valid),
        .ex_alu_op   (ex_alu_op),
        .ex_is_mul   (ex_is_mul),
        .ex_rd       (ex_rd),
        .ex_op_a     (ex_op_a),
        .ex_op_b     (ex_op_b),
        .exe_alu     (exe_alu),
        .exe_is_mul  (exe_is_mul),
        .rs_valid    (rs_valid),
        .rs_is_mul   (rs_is_mul),
        .rs_rd       (rs_rd),
        .rs_wen      (rs_wen),
        .rs_alu      (rs_alu),
        .mul_product (mul_product),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .ra          (ra),
        .rb          (rb)
    );

    rv_execute u_rv_execute (
        .clk         (clk),
        .RST_n       (RST_n),
        .ex_valid    (ex_valid),
        .ex_alu_op   (ex_alu_op),
        .ex_is_mul   (ex_is_mul),
        .ex_rd       (ex_rd),
        .ex_op_a     (ex_op_a),
        .ex_op_b     (ex_op_b),
        .exe_alu     (exe_alu),
        .exe_is_mul  (exe_is_mul),
        .rs_valid    (rs_valid),
        .rs_is_mul   (rs_is_mul),
        .rs_rd       (rs_rd),
        .rs_wen      (rs_wen),
        .rs_alu      (rs_alu),
        .mul_product (mul_product)
    );

    rv_result u_rv_result (
        .rs_valid    (rs_valid),
        .rs_is_mul   (rs_is_mul),
        .rs_rd       (rs_rd),
        .rs_wen      (rs_wen),
        .rs_alu      (rs_alu),
        .mul_product (mul_product),
        .wen         (wen),
        .waddr       (waddr),
        .wdata       (wdata)
    );

    rv_regfile u_rv_regfile (
        .clk     (clk),
        .RST_n   (RST_n),
        .raddr_a (rf_raddr_a),
        .raddr_b (rb),
        .rdata_a (rd_a),
        .rdata_b (rd_b),
        .wen     (wen),
        .waddr   (waddr),
        .wdata   (wdata)
    );

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int clk_period        = 40;
    localparam int reset_cycles      = 10;
    localparam int cycles_per_vector = 20;

    logic                   clk;
    logic                   RST_n;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    rv_core_pkg::reg_addr_t adr;
    rv_core_pkg::word_t     dat_w;
    rv_core_pkg::word_t     dat_r;
    logic                   ack;

    // One entry per vector line, kept in parallel
    byte                    kind_q[$];
    string                  name_q[$];
    rv_core_pkg::reg_addr_t reg_q[$];
    rv_core_pkg::word_t     val_q[$];
    int                     vec_count = 0;

    rv_wb_core u_rv_wb_core (
        .clk   (clk),
        .RST_n (RST_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    rv_core_checker u_rv_core_checker (
        .clk   (clk),
        .RST_n (RST_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .ack   (ack),
        .dat_r (dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    task automatic load_vectors();
        int                 fd;
        int                 n;
        int                 r;
        byte                c;
        string              line;
        string              name;
        rv_core_pkg::word_t v;
        fd = $fopen("rv_core_vectors.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                c    = (line.len() > 1) ? line.getc(0) : "#";
                name = "";
                r    = 0;
                v    = '0;
                case (c)
                    "T":     n = $sscanf(line, "T %s", name);
                    "I":     n = $sscanf(line, "I %h", v);
                    "R":     n = $sscanf(line, "R %d %h", r, v);
                    default: n = 0;  // Comments and blank lines
                endcase
                if (n > 0) begin
                    kind_q.push_back(c);
                    name_q.push_back(name);
                    reg_q.push_back(r[4:0]);
                    val_q.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
    endtask

    // One Wishbone classic cycle, stb dropped once ack is seen
    task automatic bus_cycle(input logic write, input rv_core_pkg::reg_addr_t a,
                             input rv_core_pkg::word_t d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        dat_w <= d;
        do @(posedge clk); while (!ack);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic run_vectors();
        bit in_test;
        bit prev_issue;
        in_test    = 1'b0;
        prev_issue = 1'b0;
        for (int i = 0; i < kind_q.size(); i++) begin
            case (kind_q[i])
                "T": begin
                    if (in_test) u_rv_core_checker.end_test();
                    u_rv_core_checker.start_test(name_q[i]);
                    in_test    = 1'b1;
                    prev_issue = 1'b0;
                end
                "I": begin
                    // Dependent issues go back to back
                    if (!prev_issue) idle_gap();
                    bus_cycle(1'b1, '0, val_q[i]);
                    prev_issue = 1'b1;
                end
                default: begin
                    idle_gap();
                    u_rv_core_checker.expect_read(reg_q[i], val_q[i]);
                    bus_cycle(1'b0, reg_q[i], '0);
                    prev_issue = 1'b0;
                end
            endcase
        end
        if (in_test) u_rv_core_checker.end_test();
    endtask

    initial begin
        int total_errors;
        RST_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        total_errors = 0;
        void'($urandom(32'hf69a_2a09));
        load_vectors();
        if (kind_q.size() == 0) begin
            $display("No vectors could be read from rv_core_vectors.txt");
            total_errors++;
        end else begin
            vec_count = kind_q.size();  // Starts the watchdog
            repeat (reset_cycles) @(posedge clk);
            RST_n <= 1'b1;
            run_vectors();
            repeat (2) @(posedge clk);
        end
        if (u_rv_core_checker.pending() != 0) begin
            $display("%0d expected reads were never acknowledged",
                     u_rv_core_checker.pending());
            total_errors++;
        end
        total_errors += u_rv_core_checker.error_count;
        total_errors += u_rv_wb_core.u_rv_core_asserts.fail_count;
        $display("Tests: %0d, reads checked: %0d, errors: %0d",
                 u_rv_core_checker.test_count, u_rv_core_checker.check_count, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (vec_count > 0);
        repeat (vec_count * cycles_per_vector + reset_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles",
                 vec_count * cycles_per_vector + reset_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
